// File: cpu_lite.f
+incdir+include
verilog/cpu_pkg.sv
verilog/rf_if.sv
verilog/phase_sched.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/cpu_core.sv
verilog/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// File: testbench/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;
   import cpu_pkg::*;

   typedef struct packed {
      logic [7:0][31:0] prog;
      logic [3:0]       n;            // instructions to run
      logic             st_en;
      logic [31:0]      st_addr;
      logic [31:0]      st_data;
      logic [3:0]       fetch_no;
      logic [31:0]      fetch_addr;
      logic [3:0]       sel;          // probed register
      logic [31:0]      val;
   } row_t;

   localparam int max_cycles = 64;

   logic        clk;
   logic        rst_n;
   logic [31:0] mbus_din;
   logic [3:0]  test_rsel;
   logic [31:0] mbus_addr;
   logic [31:0] mbus_dout;
   logic        mbus_wen;
   logic [31:0] test_reg;
   logic [3:0]  phase_stat;
   logic [31:0] mem [256];
   row_t        tests [$];
   row_t        cur;
   int          test_idx;
   int          rows_done;
   logic        probe;
   logic        test_end;
   logic        timed_out;
   int          err_total;
   int          fail_cnt;

   cpu_top cpu_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .mbus_din   (mbus_din),
      .test_rsel  (test_rsel),
      .mbus_addr  (mbus_addr),
      .mbus_dout  (mbus_dout),
      .mbus_wen   (mbus_wen),
      .test_reg   (test_reg),
      .phase_stat (phase_stat)
   );

   cpu_checker cpu_checker_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .mbus_addr      (mbus_addr),
      .mbus_dout      (mbus_dout),
      .mbus_wen       (mbus_wen),
      .test_reg       (test_reg),
      .phase_stat     (phase_stat),
      .test_idx       (test_idx),
      .exp_st_en      (cur.st_en),
      .exp_st_addr    (cur.st_addr),
      .exp_st_data    (cur.st_data),
      .exp_fetch_no   (cur.fetch_no),
      .exp_fetch_addr (cur.fetch_addr),
      .exp_reg        (cur.val),
      .probe          (probe),
      .test_end       (test_end),
      .err_total      (err_total),
      .fail_cnt       (fail_cnt)
   );

   // word-addressed memory, read is combinational
   assign mbus_din = mem[mbus_addr[7:0]];

   always @(posedge clk)
   begin
      if (mbus_wen)
         mem[mbus_addr[7:0]] <= mbus_dout;
   end

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic logic [31:0] fill_word(input int addr);
      return {8'hd0, addr[7:0] ^ 8'h3c, ~addr[7:0], addr[7:0]};
   endfunction

   function automatic logic [31:0] enc_alu_imm(input cond_e cnd, input alu_op_e op,
                                               input logic [3:0] rd, input logic [15:0] imm);
      return {cnd, alu_imm, 1'b0, rd, op, imm};
   endfunction

   function automatic logic [31:0] enc_alu_rr(input alu_op_e op, input logic [3:0] rd,
                                              input logic [3:0] rb);
      return {c_always, alu_rr, 1'b0, rd, op, 4'h0, rb, 8'h00};
   endfunction

   function automatic logic [31:0] enc_mem(input inst_class_e cls, input logic w,
                                           input logic [3:0] rd, input logic [3:0] ra,
                                           input logic [15:0] low);
      return {c_always, cls, w, rd, ra, low};
   endfunction

   // mov r15 to its own address, parks the core
   function automatic logic [31:0] enc_halt(input int addr);
      return enc_alu_imm(c_always, mov, 4'd15, 16'(addr));
   endfunction

   task automatic build_table();
      row_t        r;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      logic [15:0] d;
      logic [15:0] e;
      logic [15:0] off;
      logic [15:0] k;
      a   = 16'($urandom()) | 16'h8000;        // both negative so the sum wraps
      b   = 16'($urandom()) | 16'h8000;
      c   = 16'($urandom());
      d   = 16'($urandom()) | 16'h0001;        // never zero
      e   = 16'($urandom());
      off = 16'($urandom()) | 16'hfff0;        // -16..-1
      k   = 16'($urandom() % 15) + 16'd1;
      r = '0;
      r.prog[0] = enc_alu_imm(c_always, mov, 4'd1, a);
      r.prog[1] = enc_alu_imm(c_always, mov, 4'd2, b);
      r.prog[2] = enc_alu_rr(add, 4'd1, 4'd2);
      r.n   = 3;
      r.sel = 1;
      r.val = sext16(a) + sext16(b);
      tests.push_back(r);
      r = '0;
      r.prog[0] = enc_alu_imm(c_always, mov, 4'd2, 16'd3);
      r.prog[1] = enc_alu_imm(c_always, mov, 4'd1, c);
      r.prog[2] = enc_alu_imm(c_always, sub, 4'd1, c);
      r.prog[3] = enc_alu_imm(c_ne, mov, 4'd2, 16'd9);    // skipped, z is set
      r.prog[4] = enc_alu_imm(c_eq, add, 4'd2, 16'd7);
      r.n   = 5;
      r.sel = 2;
      r.val = 32'd3 + 32'd7;                     // 9 + 7 if ne ran
      tests.push_back(r);
      r = '0;
      r.prog[0] = enc_alu_imm(c_always, mov, 4'd3, d);
      r.prog[1] = enc_alu_imm(c_always, cmp, 4'd3, d);
      r.prog[2] = enc_alu_imm(c_ne, mov, 4'd3, 16'd0);
      r.prog[3] = enc_alu_imm(c_eq, add, 4'd3, 16'd1);
      r.n   = 4;
      r.sel = 3;
      r.val = sext16(d) + 32'd1;
      tests.push_back(r);
      r = '0;
      r.prog[0] = enc_alu_imm(c_always, mov, 4'd4, 16'h0040);
      r.prog[1] = enc_alu_imm(c_always, mov, 4'd5, e);
      r.prog[2] = enc_mem(st_i, 1'b0, 4'd5, 4'd4, off);
      r.n       = 3;
      r.st_en   = 1'b1;
      r.st_addr = 32'h40 + sext16(off);
      r.st_data = sext16(e);
      r.sel     = 4;
      r.val     = 32'h40;                      // no base update without w
      tests.push_back(r);
      r = '0;
      r.prog[0] = enc_alu_imm(c_always, mov, 4'd6, 16'h0020);
      r.prog[1] = enc_alu_imm(c_always, mov, 4'd7, k);
      r.prog[2] = enc_mem(ld_r, 1'b1, 4'd8, 4'd6, {4'h0, 4'd7, 8'h00});
      r.n   = 3;
      r.sel = 6;
      r.val = 32'h20 + k;
      tests.push_back(r);
      r.sel = 8;                                 // same program, loaded word
      r.val = fill_word(32'h20 + k);
      tests.push_back(r);
      r = '0;
      r.prog[0]    = enc_alu_imm(c_always, mov, 4'd9, 16'd1);
      r.prog[1]    = {c_always, call, 1'b0, 24'd6};
      r.n          = 2;
      r.fetch_no   = 3;
      r.fetch_addr = 32'd6;
      r.sel        = 14;
      r.val        = 32'd2;                      // call address plus 1
      tests.push_back(r);
   endtask

   task automatic load_memory(input row_t r);
      for (int i = 0; i < 256; i++)
         mem[i] = fill_word(i);
      for (int i = 0; i < 8; i++)
         mem[i] = (i < r.n) ? r.prog[i] : enc_halt(i);
   endtask

   task automatic run_row(input int idx);
      int cycles;
      int wb_seen;
      @(posedge clk);
      #1;
      cur      = tests[idx];
      test_idx = idx;
      rst_n    = 1'b0;
      load_memory(cur);
      repeat (10) @(posedge clk);
      #1;
      rst_n   = 1'b1;
      cycles  = 0;
      wb_seen = 0;
      while (wb_seen < cur.n && cycles < max_cycles)
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (phase_stat == ph_wb)
            wb_seen++;
      end
      if (wb_seen < cur.n)
      begin
         $display("test %0d: timed out, %0d of %0d instructions finished", idx, wb_seen, cur.n);
         timed_out = 1'b1;
      end
      else
      begin
         test_rsel = cur.sel;    // settles while the last writeback lands
         @(posedge clk);
         #1;
         probe = 1'b1;
         @(posedge clk);
         #1;
         probe    = 1'b0;
         test_end = 1'b1;
         @(posedge clk);
         #1;
         test_end = 1'b0;
      end
   endtask

   initial
   begin
      rst_n     = 1'b0;
      test_rsel = '0;
      probe     = 1'b0;
      test_end  = 1'b0;
      timed_out = 1'b0;
      test_idx  = 0;
      rows_done = 0;
      cur       = '0;
      void'($urandom(32'hbcdc));
      build_table();
      for (int i = 0; i < tests.size() && !timed_out; i++)
      begin
         run_row(i);
         rows_done++;
      end
      @(posedge clk);
      #1;
      $display("tests run %0d, failed %0d, errors %0d", rows_done,
               fail_cnt + (timed_out ? 1 : 0), err_total);
      if (err_total == 0 && !timed_out)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: testbench/cpu_checker.sv
`timescale 1ns/1ns

module cpu_checker
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] mbus_addr,
   input  logic [31:0] mbus_dout,
   input  logic        mbus_wen,
   input  logic [31:0] test_reg,
   input  logic [3:0]  phase_stat,
   input  int          test_idx,
   input  logic        exp_st_en,
   input  logic [31:0] exp_st_addr,
   input  logic [31:0] exp_st_data,
   input  logic [3:0]  exp_fetch_no,     // 0 means no fetch check
   input  logic [31:0] exp_fetch_addr,
   input  logic [31:0] exp_reg,
   input  logic        probe,
   input  logic        test_end,
   output int          err_total,
   output int          fail_cnt
);
   import cpu_pkg::*;

   int   test_err;
   int   fetch_cnt;
   int   inst_cyc;       // 1 in fetch, 3 in mem
   logic store_seen;
   logic first_cyc;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
         test_err++;
      end
   endtask

   task automatic check_store();
      if (!exp_st_en || store_seen)
      begin
         $display("at %0t: unexpected store to %h with data %h", $time, mbus_addr, mbus_dout);
         test_err++;
      end
      else
      begin
         compare("mbus_addr", mbus_addr, exp_st_addr);
         compare("mbus_dout", mbus_dout, exp_st_data);
      end
      compare("phase_stat", 32'(phase_stat), 32'(ph_mem));
      compare("store cycle", inst_cyc, 3);
      store_seen = 1'b1;
   endtask

   task automatic finish_test();
      if (exp_st_en && !store_seen)
      begin
         $display("at %0t: expected store to %h never appeared on the bus", $time, exp_st_addr);
         test_err++;
      end
      if (test_err == 0)
         $display("test %0d: ok", test_idx);
      else
         $display("test %0d: failed with %0d errors", test_idx, test_err);
      err_total += test_err;
      if (test_err != 0)
         fail_cnt++;
      test_err = 0;
   endtask

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         if (mbus_wen === 1'b1)
         begin
            $display("at %0t: store strobe high while reset is asserted", $time);
            test_err++;
         end
         first_cyc  = 1'b1;
         store_seen = 1'b0;
         fetch_cnt  = 0;
         inst_cyc   = 0;
      end
      else
      begin
         if (first_cyc)
         begin
            compare("phase_stat", 32'(phase_stat), 32'(ph_fetch));   // first cycle out of reset
            compare("mbus_addr", mbus_addr, 32'h0);
            first_cyc = 1'b0;
         end
         if (phase_stat == ph_fetch)
         begin
            inst_cyc = 1;
            fetch_cnt++;
            if (fetch_cnt == exp_fetch_no)
               compare("mbus_addr", mbus_addr, exp_fetch_addr);
         end
         else
            inst_cyc++;
         if (mbus_wen)
            check_store();
         if (probe)
            compare("test_reg", test_reg, exp_reg);
         if (test_end)
            finish_test();
      end
   end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
#(
   parameter int WIDTH     = cpu_pkg::data_w,
   parameter int ADDR_SIZE = cpu_pkg::addr_w
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [WIDTH-1:0]     mbus_din,
   input  logic [3:0]           test_rsel,
   output logic [ADDR_SIZE-1:0] mbus_addr,
   output logic [WIDTH-1:0]     mbus_dout,
   output logic                 mbus_wen,
   output logic [WIDTH-1:0]     test_reg,
   output logic [3:0]           phase_stat
);
   import cpu_pkg::*;

   phase_e           phase;
   alu_op_e          alu_op;
   logic [WIDTH-1:0] alu_a;
   logic [WIDTH-1:0] alu_b;
   logic [WIDTH-1:0] alu_res;
   logic [7:0]       alu_fi;
   logic [7:0]       alu_fo;
   logic             alu_wb_ok;

   rf_if #(.WIDTH(WIDTH)) rf_bus ();

   phase_sched phase_sched_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .phase (phase)
   );

   cpu_core #(.WIDTH(WIDTH), .ADDR_SIZE(ADDR_SIZE)) cpu_core_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .phase     (phase),
      .rf        (rf_bus.core),
      .alu_op    (alu_op),
      .alu_a     (alu_a),
      .alu_b     (alu_b),
      .alu_fi    (alu_fi),
      .alu_res   (alu_res),
      .alu_fo    (alu_fo),
      .alu_wb_ok (alu_wb_ok),
      .mbus_addr (mbus_addr),
      .mbus_din  (mbus_din),
      .mbus_dout (mbus_dout),
      .mbus_wen  (mbus_wen)
   );

   reg_file #(.WIDTH(WIDTH)) reg_file_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .rf       (rf_bus.rf),
      .dbg_sel  (test_rsel),
      .dbg_data (test_reg)
   );

   alu alu_inst (
      .op    (alu_op),
      .a     (alu_a),
      .b     (alu_b),
      .fi    (alu_fi),
      .res   (alu_res),
      .fo    (alu_fo),
      .wb_ok (alu_wb_ok)
   );

   assign phase_stat = phase;

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ns
`include "cpu_flags.svh"

module cpu_core
#(
   parameter int WIDTH     = 32,
   parameter int ADDR_SIZE = 32
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  cpu_pkg::phase_e      phase,
   rf_if.core                   rf,
   output cpu_pkg::alu_op_e     alu_op,
   output logic [WIDTH-1:0]     alu_a,
   output logic [WIDTH-1:0]     alu_b,
   output logic [7:0]           alu_fi,
   input  logic [WIDTH-1:0]     alu_res,
   input  logic [7:0]           alu_fo,
   input  logic                 alu_wb_ok,
   output logic [ADDR_SIZE-1:0] mbus_addr,
   input  logic [WIDTH-1:0]     mbus_din,
   output logic [WIDTH-1:0]     mbus_dout,
   output logic                 mbus_wen
);
   import cpu_pkg::*;

   localparam int sel_w = $clog2(reg_cnt);

   logic [WIDTH-1:0]     ir;
   logic [7:0]           flags;
   logic [WIDTH-1:0]     ld_q;        // word read in the mem phase
   cond_e                cond;
   inst_class_e          cls;
   logic                 w_bit;
   logic [sel_w-1:0]     rd;
   logic [sel_w-1:0]     ra;
   logic [sel_w-1:0]     rb;
   logic [15:0]          imm16;
   logic [23:0]          imm24;
   logic                 ph_f;
   logic                 ph_e;
   logic                 ph_m;
   logic                 ph_w;
   logic                 pass;
   logic                 is_alu;
   logic                 is_imm;
   logic                 is_call;
   logic                 is_st;
   logic                 is_ld;
   logic                 is_mem;
   logic [WIDTH-1:0]     imm_sx;
   logic [WIDTH-1:0]     call_tgt;
   logic [WIDTH-1:0]     eff_addr;
   logic [ADDR_SIZE-1:0] pc_addr;
   logic [ADDR_SIZE-1:0] ea_addr;

   assign cond  = cond_e'(ir[cond_msb:cond_lsb]);
   assign cls   = inst_class_e'(ir[class_msb:class_lsb]);
   assign w_bit = ir[wb_bit];
   assign rd    = ir[rd_msb:rd_lsb];
   assign ra    = ir[ra_msb:ra_lsb];
   assign rb    = ir[rb_msb:rb_lsb];
   assign imm16 = ir[imm16_msb:imm_lsb];
   assign imm24 = ir[imm24_msb:imm_lsb];

   assign ph_f = (phase == ph_fetch);
   assign ph_e = (phase == ph_exec);
   assign ph_m = (phase == ph_mem);
   assign ph_w = (phase == ph_wb);

   always_comb
   begin
      is_alu  = 1'b0;
      is_imm  = 1'b0;
      is_call = 1'b0;
      is_st   = 1'b0;
      is_ld   = 1'b0;
      case (cls)
         alu_rr:
            is_alu = 1'b1;
         alu_imm:
         begin
            is_alu = 1'b1;
            is_imm = 1'b1;
         end
         call:
            is_call = 1'b1;
         ext:
            ;                     // extension class runs as a no-op
         st_r:
            is_st = 1'b1;
         ld_r:
            is_ld = 1'b1;
         st_i:
         begin
            is_st  = 1'b1;
            is_imm = 1'b1;
         end
         ld_i:
         begin
            is_ld  = 1'b1;
            is_imm = 1'b1;
         end
         default:
            ;
      endcase
   end

   assign is_mem = is_st | is_ld;

   // condition test against the current flags
   always_comb
   begin
      case (cond)
         c_always: pass = 1'b1;
         c_eq:     pass = flags[`ZIDX];
         c_ne:     pass = !flags[`ZIDX];
         c_cs:     pass = flags[`CIDX];
         c_cc:     pass = !flags[`CIDX];
         c_mi:     pass = flags[`SIDX];
         c_pl:     pass = !flags[`SIDX];
         c_vs:     pass = flags[`VIDX];
         c_vc:     pass = !flags[`VIDX];
         c_never:  pass = 1'b0;
         default:  pass = 1'b0;
      endcase
   end

   assign imm_sx   = {{(WIDTH-16){imm16[15]}}, imm16};
   assign call_tgt = {{(WIDTH-24){1'b0}}, imm24};      // absolute, zero-extended
   assign eff_addr = rf.da + (is_imm ? imm_sx : rf.db);

   // alu form is rd <- rd op (rb | imm16)
   assign alu_op = alu_op_e'(ra);
   assign alu_a  = rf.dd;
   assign alu_b  = is_imm ? imm_sx : rf.db;
   assign alu_fi = flags;

   assign rf.ra_sel    = is_call ? sel_w'(link_idx) : ra;
   assign rf.rb_sel    = rb;
   assign rf.rd_sel    = rd;
   assign rf.pc_inc    = ph_e;
   assign rf.wb_en     = pass && ph_w && ((is_alu && alu_wb_ok) || is_ld || is_call);
   assign rf.wb_sel    = is_call ? sel_w'(pc_idx) : rd;
   assign rf.wb_data   = is_call ? call_tgt : (is_ld ? ld_q : alu_res);
   assign rf.base_en   = pass && ((is_mem && w_bit && ph_m) || (is_call && ph_w));
   assign rf.base_data = is_call ? rf.pc : eff_addr;   // link is pc after the increment

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ir    <= '0;
         flags <= '0;
      end
      else
      begin
         if (ph_f)
            ir <= mbus_din;
         if (ph_w && pass && is_alu)
            flags <= alu_fo;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ph_m && is_ld)
         ld_q <= mbus_din;
   end

   assign pc_addr = ADDR_SIZE'(rf.pc);
   assign ea_addr = ADDR_SIZE'(eff_addr);

   always_comb
   begin
      case (phase)
         ph_exec: mbus_addr = is_ld ? ea_addr : pc_addr;
         ph_mem:  mbus_addr = is_mem ? ea_addr : pc_addr;
         default: mbus_addr = pc_addr;
      endcase
   end

   assign mbus_dout = rf.dd;
   assign mbus_wen  = pass && is_st && ph_m;

   // a store puts a known address and word on the bus in the mem phase
   store_in_mem: assert property (
      @(posedge clk) disable iff (!rst_n)
         mbus_wen |-> (phase == ph_mem) && !$isunknown({mbus_addr, mbus_dout})
   );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file
#(
   parameter int WIDTH = 32
)
(
   input  logic             clk,
   input  logic             rst_n,
   rf_if.rf                 rf,
   input  logic [3:0]       dbg_sel,
   output logic [WIDTH-1:0] dbg_data
);
   import cpu_pkg::*;

   localparam int sel_w = $clog2(reg_cnt);

   logic [WIDTH-1:0] regs [reg_cnt-1];   // r0..r14
   logic [WIDTH-1:0] pc_q;               // r15 kept apart

   function automatic logic [WIDTH-1:0] read_reg(input logic [sel_w-1:0] sel);
      if (sel == sel_w'(pc_idx))
         return pc_q;
      else
         return regs[sel];
   endfunction

   always_comb
   begin
      rf.da    = read_reg(rf.ra_sel);
      rf.db    = read_reg(rf.rb_sel);
      rf.dd    = read_reg(rf.rd_sel);
      rf.pc    = pc_q;
      dbg_data = read_reg(dbg_sel);
   end

   // writeback wins over base update
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < reg_cnt - 1; i++)
      begin
         if (rf.wb_en && rf.wb_sel == sel_w'(i))
            regs[i] <= rf.wb_data;
         else if (rf.base_en && rf.ra_sel == sel_w'(i))
            regs[i] <= rf.base_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pc_q <= '0;
      else if (rf.wb_en && rf.wb_sel == sel_w'(pc_idx))
         pc_q <= rf.wb_data;     // jump, seen on the next fetch
      else if (rf.base_en && rf.ra_sel == sel_w'(pc_idx))
         pc_q <= rf.base_data;
      else if (rf.pc_inc)
         pc_q <= pc_q + 1'b1;
   end

   // call writes r15 and r14 together, never the same register twice
   wb_base_distinct: assert property (
      @(posedge clk) disable iff (!rst_n)
         (rf.wb_en && rf.base_en) |-> (rf.wb_sel != rf.ra_sel)
   );

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns
`include "cpu_flags.svh"

module alu
(
   input  cpu_pkg::alu_op_e           op,
   input  logic [cpu_pkg::data_w-1:0] a,
   input  logic [cpu_pkg::data_w-1:0] b,
   input  logic [7:0]                 fi,
   output logic [cpu_pkg::data_w-1:0] res,
   output logic [7:0]                 fo,
   output logic                       wb_ok
);
   import cpu_pkg::*;

   localparam int msb = data_w - 1;

   logic [data_w:0] sum;     // carry out in the top bit
   logic [data_w:0] diff;
   logic            c_new;
   logic            v_new;

   assign sum  = {1'b0, a} + {1'b0, b};
   assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;   // carry set means no borrow

   always_comb
   begin
      res   = '0;
      c_new = fi[`CIDX];    // logic ops keep c and v
      v_new = fi[`VIDX];
      wb_ok = 1'b1;
      case (op)
         add:
         begin
            res   = sum[msb:0];
            c_new = sum[data_w];
            v_new = (a[msb] == b[msb]) && (res[msb] != a[msb]);
         end
         sub, cmp:
         begin
            res   = diff[msb:0];
            c_new = diff[data_w];
            v_new = (a[msb] != b[msb]) && (res[msb] != a[msb]);
            wb_ok = (op == sub);
         end
         and_op, tst:
         begin
            res   = a & b;
            wb_ok = (op == and_op);
         end
         or_op:
            res = a | b;
         xor_op:
            res = a ^ b;
         mov:
            res = b;
         shl:
            res = a << b[4:0];
         shr:
            res = a >> b[4:0];    // logical
         default:
            wb_ok = 1'b0;        // undefined op writes nothing
      endcase
   end

   // zero and sign always follow the result
   always_comb
   begin
      fo         = fi;
      fo[`CIDX]  = c_new;
      fo[`VIDX]  = v_new;
      fo[`ZIDX]  = (res == '0);
      fo[`SIDX]  = res[msb];
   end

endmodule

// File: verilog/phase_sched.sv
`timescale 1ns/1ns

module phase_sched
(
   input  logic            clk,
   input  logic            rst_n,
   output cpu_pkg::phase_e phase
);
   import cpu_pkg::*;

   // one-hot ring, one phase per clock
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         phase <= ph_fetch;
      end
      else
      begin
         case (phase)
            ph_fetch:
               phase <= ph_exec;
            ph_exec:
               phase <= ph_mem;
            ph_mem:
               phase <= ph_wb;
            ph_wb:
               phase <= ph_fetch;    // next instruction
            default:
               phase <= ph_fetch;    // recover from a bad state
         endcase
      end
   end

   phase_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
         $onehot(phase)
   );

endmodule

// File: verilog/rf_if.sv
`timescale 1ns/1ns

interface rf_if
#(
   parameter int WIDTH = 32
)
();
   import cpu_pkg::*;

   localparam int sel_w = $clog2(reg_cnt);

   logic [sel_w-1:0] ra_sel;     // base / first operand
   logic [sel_w-1:0] rb_sel;
   logic [sel_w-1:0] rd_sel;     // destination, also store data
   logic [WIDTH-1:0] da;
   logic [WIDTH-1:0] db;
   logic [WIDTH-1:0] dd;
   logic             wb_en;
   logic [sel_w-1:0] wb_sel;
   logic [WIDTH-1:0] wb_data;
   logic             base_en;    // writes register ra_sel
   logic [WIDTH-1:0] base_data;
   logic             pc_inc;
   logic [WIDTH-1:0] pc;

   modport core (output ra_sel, rb_sel, rd_sel, wb_en, wb_sel, wb_data,
                 output base_en, base_data, pc_inc,
                 input  da, db, dd, pc);

   modport rf (input  ra_sel, rb_sel, rd_sel, wb_en, wb_sel, wb_data,
               input  base_en, base_data, pc_inc,
               output da, db, dd, pc);

endinterface

// File: verilog/cpu_pkg.sv
package cpu_pkg;

   localparam int data_w   = 32;
   localparam int addr_w   = 32;
   localparam int reg_cnt  = 16;
   localparam int pc_idx   = 15;    // r15 is the program counter
   localparam int link_idx = 14;    // call links here

   // instruction word layout
   localparam int cond_msb  = 31;
   localparam int cond_lsb  = 28;
   localparam int class_msb = 27;
   localparam int class_lsb = 25;
   localparam int wb_bit    = 24;   // base write-back on ld/st
   localparam int rd_msb    = 23;
   localparam int rd_lsb    = 20;
   localparam int ra_msb    = 19;   // also the alu op field
   localparam int ra_lsb    = 16;
   localparam int rb_msb    = 11;
   localparam int rb_lsb    = 8;
   localparam int imm16_msb = 15;
   localparam int imm24_msb = 23;
   localparam int imm_lsb   = 0;

   typedef enum logic [2:0] {
      alu_rr, alu_imm, call, ext, st_r, ld_r, st_i, ld_i
   } inst_class_e;

   typedef enum logic [3:0] {
      c_always, c_eq, c_ne, c_cs, c_cc, c_mi, c_pl, c_vs, c_vc, c_never
   } cond_e;

   // cmp and tst only touch the flags
   typedef enum logic [3:0] {
      add, sub, and_op, or_op, xor_op, mov, shl, shr, cmp, tst
   } alu_op_e;

   typedef enum logic [3:0] {
      ph_fetch = 4'b0001,
      ph_exec  = 4'b0010,
      ph_mem   = 4'b0100,
      ph_wb    = 4'b1000
   } phase_e;

endpackage

// File: include/cpu_flags.svh
`ifndef CPU_FLAGS_SVH
`define CPU_FLAGS_SVH

// bit positions inside the 8-bit flag register
`define CIDX 0
`define SIDX 1
`define ZIDX 2
`define VIDX 3

`endif
